// ==== alu_core.sv ====
module alu_core
    import exu_pkg::*;
(
    // resolved operands
    input  ex_ops_t         ops,
    // final result, also seen by branch logic
    output logic [xlen-1:0] alu_result,
    // result toward mem
    output ex_mem_t         result
);

    alu_fn_e         fn;
    logic            is_word;
    logic            is_reg_op;
    logic            is_alu_op;
    logic [5:0]      shamt;
    logic [xlen-1:0] raw;

    assign is_word   = (ops.entry.op_class == cls_op_w) || (ops.entry.op_class == cls_op_imm_w);
    assign is_reg_op = (ops.entry.op_class == cls_op) || (ops.entry.op_class == cls_op_w);
    assign is_alu_op = is_word || (ops.entry.op_class == cls_op) ||
                       (ops.entry.op_class == cls_op_imm);

    // function decode
    always_comb begin
        fn = fn_add;
        if (ops.entry.op_class == cls_branch) begin
            // compare by subtraction
            fn = fn_sub;
        end else if (is_alu_op) begin
            case (ops.entry.funct3)
                f3_add_sub: begin
                    // imm[10] is funct7 bit 5, sub only for register form
                    fn = (is_reg_op && ops.entry.imm[10]) ? fn_sub : fn_add;
                end
                f3_sll: begin
                    fn = fn_sll;
                end
                f3_sr: begin
                    // srai also carries the bit in imm[10]
                    fn = ops.entry.imm[10] ? fn_sra : fn_srl;
                end
                f3_slt: begin
                    fn = is_word ? fn_add : fn_slt;
                end
                f3_sltu: begin
                    fn = is_word ? fn_add : fn_sltu;
                end
                f3_xor: begin
                    fn = is_word ? fn_add : fn_xor;
                end
                f3_or: begin
                    fn = is_word ? fn_add : fn_or;
                end
                f3_and: begin
                    fn = is_word ? fn_add : fn_and;
                end
                default: begin
                    fn = fn_add;
                end
            endcase
        end
    end

    // word shift amounts are already masked to 5 bits
    assign shamt = ops.op_b[5:0];

    // 64-bit datapath
    always_comb begin
        case (fn)
            fn_sub:  raw = ops.op_a - ops.op_b;
            fn_slt:  raw = xlen'($signed(ops.op_a) < $signed(ops.op_b));
            fn_sltu: raw = xlen'(ops.op_a < ops.op_b);
            fn_and:  raw = ops.op_a & ops.op_b;
            fn_or:   raw = ops.op_a | ops.op_b;
            fn_xor:  raw = ops.op_a ^ ops.op_b;
            fn_sll:  raw = ops.op_a << shamt;
            fn_srl:  raw = ops.op_a >> shamt;
            fn_sra:  raw = $signed(ops.op_a) >>> shamt;
            default: raw = ops.op_a + ops.op_b;
        endcase
    end

    // word results sign-extended from bit 31
    // right word shifts ran in the upper half, take it down
    always_comb begin
        if (is_word && (ops.entry.funct3 == f3_sr)) begin
            alu_result = {{(xlen-word_w){raw[xlen-1]}}, raw[xlen-1 -: word_w]};
        end else if (is_word) begin
            alu_result = {{(xlen-word_w){raw[word_w-1]}}, raw[word_w-1:0]};
        end else begin
            alu_result = raw;
        end
    end

    assign result.valid      = ops.entry.valid;
    assign result.pc         = ops.entry.pc;
    assign result.op_class   = ops.entry.op_class;
    assign result.funct3     = ops.entry.funct3;
    assign result.rd         = ops.entry.rd;
    assign result.alu_result = alu_result;
    // store data after forwarding
    assign result.store_data = ops.rs2_val;

endmodule

// ==== branch_resolve.sv ====
module branch_resolve
    import exu_pkg::*;
(
    // resolved operands
    input  ex_ops_t         ops,
    // rs1 - rs2 for branches
    input  logic [xlen-1:0] alu_result,
    // entry actually leaves this cycle
    input  logic            ready_ex_mem,
    // redirect toward fetch
    output redirect_t       redirect
);

    logic            is_branch;
    logic            is_jalr;
    logic            backward;
    logic            sign_diff;
    logic            lt_s;
    logic            lt_u;
    logic            taken;
    logic [xlen-1:0] target;

    assign is_branch = ops.entry.op_class == cls_branch;
    assign is_jalr   = ops.entry.op_class == cls_jalr;
    // offset sign, decode predicted backward as taken
    assign backward  = ops.entry.imm[12];

    // compares from the subtract, sign bits settle overflow
    assign sign_diff = ops.rs1_val[xlen-1] ^ ops.rs2_val[xlen-1];
    assign lt_s = sign_diff ? ops.rs1_val[xlen-1] : alu_result[xlen-1];
    assign lt_u = sign_diff ? ops.rs2_val[xlen-1] : alu_result[xlen-1];

    always_comb begin
        case (ops.entry.funct3)
            beq:     taken = alu_result == '0;
            bne:     taken = alu_result != '0;
            blt:     taken = lt_s;
            bge:     taken = !lt_s;
            bltu:    taken = lt_u;
            bgeu:    taken = !lt_u;
            default: taken = 1'b0;
        endcase
    end

    // jalr from rs1, branch from pc, bit 0 left as is
    assign target = (is_branch ? ops.entry.pc : ops.rs1_val) + ops.entry.imm;

    // mispredict when outcome differs from the static guess
    assign redirect.pc_update = ops.entry.valid && ready_ex_mem &&
                                (is_jalr || (is_branch && (taken ^ backward)));

    // fall-through for backward branches and everything else
    assign redirect.dnpc = (is_jalr || (is_branch && !backward)) ? target :
                           ops.entry.pc + xlen'(4);

endmodule

// ==== ex_issue_reg.sv ====
module ex_issue_reg
    import exu_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n,
    // entry from decode
    input  id_ex_t id_ex,
    // downstream can take the held entry
    input  logic   ready,
    // misprediction kill, level
    input  logic   flush,
    // entry held in ex
    output id_ex_t entry
);

    // id/ex pipeline register
    // flush beats stall, stall holds
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            entry <= '0;
        end else if (flush) begin
            // wrong-path entry dropped
            entry <= '0;
        end else if (ready) begin
            // old entry leaves, new one lands
            entry <= id_ex;
        end
        // else hold while mem is stalled
    end

endmodule

// ==== exu_pkg.sv ====
package exu_pkg;

    // data path width, fixed by rv64
    localparam int xlen = 64;
    // register index width
    localparam int reg_idx_w = 5;
    // width of a word operation
    localparam int word_w = 32;

    // operation class, set by decode
    typedef enum logic [3:0] {
        cls_lui,
        cls_auipc,
        cls_jal,
        cls_jalr,
        cls_branch,
        cls_load,
        cls_store,
        cls_op_imm,
        cls_op,
        cls_op_imm_w,
        cls_op_w,
        cls_other
    } op_class_e;

    // funct3 of the integer alu operations
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_sr      = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // funct3 of the conditional branches
    localparam logic [2:0] beq  = 3'b000;
    localparam logic [2:0] bne  = 3'b001;
    localparam logic [2:0] blt  = 3'b100;
    localparam logic [2:0] bge  = 3'b101;
    localparam logic [2:0] bltu = 3'b110;
    localparam logic [2:0] bgeu = 3'b111;

    // alu function
    typedef enum logic [3:0] {
        fn_add,
        fn_sub,
        fn_slt,
        fn_sltu,
        fn_and,
        fn_or,
        fn_xor,
        fn_sll,
        fn_srl,
        fn_sra
    } alu_fn_e;

    // entry presented by decode
    // funct7 sits in imm[11:5] for register ops
    typedef struct packed {
        logic                 valid;
        logic [xlen-1:0]      pc;
        op_class_e            op_class;
        logic [2:0]           funct3;
        logic [reg_idx_w-1:0] rd;
        logic [reg_idx_w-1:0] rs1;
        logic [reg_idx_w-1:0] rs2;
        logic [xlen-1:0]      src_a;
        logic [xlen-1:0]      src_b;
        logic [xlen-1:0]      imm;
    } id_ex_t;

    // one forwarding source, mem or wb
    typedef struct packed {
        logic                 writing;
        logic [reg_idx_w-1:0] rd;
        logic [xlen-1:0]      data;
    } fwd_t;

    // held entry plus resolved operands
    typedef struct packed {
        id_ex_t          entry;
        logic [xlen-1:0] rs1_val;
        logic [xlen-1:0] rs2_val;
        logic [xlen-1:0] op_a;
        logic [xlen-1:0] op_b;
    } ex_ops_t;

    // result toward mem
    typedef struct packed {
        logic                 valid;
        logic [xlen-1:0]      pc;
        op_class_e            op_class;
        logic [2:0]           funct3;
        logic [reg_idx_w-1:0] rd;
        logic [xlen-1:0]      alu_result;
        logic [xlen-1:0]      store_data;
    } ex_mem_t;

    // redirect toward fetch
    typedef struct packed {
        logic            pc_update;
        logic [xlen-1:0] dnpc;
    } redirect_t;

endpackage

// ==== exu_top.sv ====
module exu_top
    import exu_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    // decode side
    input  id_ex_t    id_ex,
    output logic      ready_id_ex,
    // mem side
    output ex_mem_t   ex_mem,
    input  logic      ready_ex_mem,
    // forwarding sources
    input  fwd_t      mem_fwd,
    input  fwd_t      wb_fwd,
    // kill from a redirect
    input  logic      branch_flush,
    // fetch side
    output redirect_t redirect
);

    id_ex_t          entry;
    ex_ops_t         ops;
    logic [xlen-1:0] alu_result;

    // no multi-cycle units, stall comes only from mem
    assign ready_id_ex = ready_ex_mem;

    ex_issue_reg u_issue (
        .clk    (clk),
        .arst_n (arst_n),
        .id_ex  (id_ex),
        .ready  (ready_id_ex),
        .flush  (branch_flush),
        .entry  (entry)
    );

    operand_forward u_fwd (
        .entry   (entry),
        .mem_fwd (mem_fwd),
        .wb_fwd  (wb_fwd),
        .ops     (ops)
    );

    alu_core u_alu (
        .ops        (ops),
        .alu_result (alu_result),
        .result     (ex_mem)
    );

    // same cycle as the alu
    branch_resolve u_br (
        .ops          (ops),
        .alu_result   (alu_result),
        .ready_ex_mem (ready_ex_mem),
        .redirect     (redirect)
    );

endmodule

// ==== operand_forward.sv ====
module operand_forward
    import exu_pkg::*;
(
    // entry held in ex
    input  id_ex_t  entry,
    // result in mem, newest
    input  fwd_t    mem_fwd,
    // result in wb, older
    input  fwd_t    wb_fwd,
    // entry with resolved operands
    output ex_ops_t ops
);

    logic            rs1_mem_hit;
    logic            rs1_wb_hit;
    logic            rs2_mem_hit;
    logic            rs2_wb_hit;
    logic            uses_rs2;
    logic            is_shift;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;

    // only these classes actually read rs2
    assign uses_rs2 = (entry.op_class == cls_branch) || (entry.op_class == cls_store) ||
                      (entry.op_class == cls_op) || (entry.op_class == cls_op_w);

    // x0 never matches
    assign rs1_mem_hit = mem_fwd.writing && (mem_fwd.rd == entry.rs1) && (entry.rs1 != '0);
    assign rs1_wb_hit  = wb_fwd.writing && (wb_fwd.rd == entry.rs1) && (entry.rs1 != '0);
    assign rs2_mem_hit = uses_rs2 && mem_fwd.writing && (mem_fwd.rd == entry.rs2) &&
                         (entry.rs2 != '0);
    assign rs2_wb_hit  = uses_rs2 && wb_fwd.writing && (wb_fwd.rd == entry.rs2) &&
                         (entry.rs2 != '0);

    // mem first, then wb, then decode value
    assign rs1_val = rs1_mem_hit ? mem_fwd.data : (rs1_wb_hit ? wb_fwd.data : entry.src_a);
    assign rs2_val = rs2_mem_hit ? mem_fwd.data : (rs2_wb_hit ? wb_fwd.data : entry.src_b);

    // sll, srl and sra share these funct3 codes
    assign is_shift = (entry.funct3 == f3_sll) || (entry.funct3 == f3_sr);

    always_comb begin
        case (entry.op_class)
            cls_lui: begin
                op_a = '0;
            end
            cls_auipc, cls_jal, cls_jalr: begin
                op_a = entry.pc;
            end
            cls_op_w, cls_op_imm_w: begin
                // word right shift runs in the upper half
                if (entry.funct3 == f3_sr) begin
                    op_a = {rs1_val[word_w-1:0], {(xlen-word_w){1'b0}}};
                end else begin
                    op_a = rs1_val;
                end
            end
            default: begin
                op_a = rs1_val;
            end
        endcase
    end

    always_comb begin
        case (entry.op_class)
            // link value pc + 4
            cls_jal, cls_jalr: op_b = xlen'(4);
            cls_op:            op_b = is_shift ? xlen'(rs2_val[5:0]) : rs2_val;
            cls_op_w:          op_b = is_shift ? xlen'(rs2_val[4:0]) : rs2_val;
            cls_op_imm:        op_b = is_shift ? xlen'(entry.imm[5:0]) : entry.imm;
            cls_op_imm_w:      op_b = is_shift ? xlen'(entry.imm[4:0]) : entry.imm;
            cls_lui, cls_auipc, cls_load, cls_store: begin
                op_b = entry.imm;
            end
            // branches compare rs1 against rs2
            default:           op_b = rs2_val;
        endcase
    end

    assign ops.entry   = entry;
    assign ops.rs1_val = rs1_val;
    assign ops.rs2_val = rs2_val;
    assign ops.op_a    = op_a;
    assign ops.op_b    = op_b;

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the exu testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing --assert -f vlog.f --top-module tb_exu -o sim_exu
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/sim_exu > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^=== PASS ===$" "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1

// ==== tb_exu.sv ====
module tb_exu
    import exu_pkg::*;
();

    localparam int half_period = 50;
    localparam int drive_dly   = 10;
    localparam int wait_limit  = 20;

    logic      clk;
    logic      arst_n;
    id_ex_t    id_ex;
    logic      ready_id_ex;
    ex_mem_t   ex_mem;
    logic      ready_ex_mem;
    fwd_t      mem_fwd;
    fwd_t      wb_fwd;
    logic      branch_flush;
    redirect_t redirect;

    integer seed;
    int     mismatches;
    int     timeouts;

    // stimulus table, one slot per row
    string     row_name[$];
    id_ex_t    row_id[$];
    fwd_t      row_mem[$];
    fwd_t      row_wb[$];
    logic      row_rdy[$];
    ex_mem_t   row_exp_em[$];
    redirect_t row_exp_rd[$];

    exu_top u_dut (
        .clk          (clk),
        .arst_n       (arst_n),
        .id_ex        (id_ex),
        .ready_id_ex  (ready_id_ex),
        .ex_mem       (ex_mem),
        .ready_ex_mem (ready_ex_mem),
        .mem_fwd      (mem_fwd),
        .wb_fwd       (wb_fwd),
        .branch_flush (branch_flush),
        .redirect     (redirect)
    );

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    function automatic logic [xlen-1:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic logic [xlen-1:0] rand_imm12();
        logic [xlen-1:0] r;
        r = rand64();
        return {{(xlen-12){r[11]}}, r[11:0]};
    endfunction

    function automatic logic [xlen-1:0] sext_word(input logic [word_w-1:0] v);
        return {{(xlen-word_w){v[word_w-1]}}, v};
    endfunction

    function automatic fwd_t make_fwd(input logic wr, input logic [reg_idx_w-1:0] dst,
                                      input logic [xlen-1:0] value);
        return '{writing: wr, rd: dst, data: value};
    endfunction

    function automatic id_ex_t make_entry(input op_class_e cls, input logic [2:0] f3,
                                          input logic [reg_idx_w-1:0] rs1,
                                          input logic [reg_idx_w-1:0] rs2,
                                          input logic [xlen-1:0] a, input logic [xlen-1:0] b,
                                          input logic [xlen-1:0] imm);
        id_ex_t e;
        e.valid    = 1'b1;
        // word aligned pc near a typical boot address
        e.pc       = 64'h8000_0000 | (rand64() & 64'h000f_fffc);
        e.op_class = cls;
        e.funct3   = f3;
        e.rd       = 5'd10;
        e.rs1      = rs1;
        e.rs2      = rs2;
        e.src_a    = a;
        e.src_b    = b;
        e.imm      = imm;
        return e;
    endfunction

    // newest writer wins, x0 stays zero-sourced
    function automatic logic [xlen-1:0] bypass(input logic [reg_idx_w-1:0] rs,
                                               input logic [xlen-1:0] reg_val,
                                               input logic eligible, input fwd_t m, input fwd_t w);
        if (eligible && rs != '0 && m.writing && m.rd == rs) return m.data;
        if (eligible && rs != '0 && w.writing && w.rd == rs) return w.data;
        return reg_val;
    endfunction

    // rv64i result per instruction class
    function automatic logic [xlen-1:0] ref_alu(input id_ex_t e, input logic [xlen-1:0] a,
                                                input logic [xlen-1:0] b);
        logic [xlen-1:0]   y;
        logic [xlen-1:0]   r;
        logic [word_w-1:0] aw;
        logic [word_w-1:0] wr;
        logic              reg_form;
        logic              alt;
        reg_form = (e.op_class == cls_op) || (e.op_class == cls_op_w);
        y        = reg_form ? b : e.imm;
        aw       = a[word_w-1:0];
        // funct7 bit 5
        alt      = e.imm[10];
        case (e.op_class)
            cls_lui:             return e.imm;
            cls_auipc:           return e.pc + e.imm;
            cls_jal, cls_jalr:   return e.pc + 64'd4;
            cls_load, cls_store: return a + e.imm;
            cls_branch:          return a - b;
            cls_op, cls_op_imm: begin
                case (e.funct3)
                    f3_add_sub: r = (reg_form && alt) ? a - y : a + y;
                    f3_sll:     r = a << y[5:0];
                    f3_slt:     r = {63'd0, $signed(a) < $signed(y)};
                    f3_sltu:    r = {63'd0, a < y};
                    f3_xor:     r = a ^ y;
                    f3_or:      r = a | y;
                    f3_and:     r = a & y;
                    default: begin
                        if (alt) r = $signed(a) >>> y[5:0];
                        else r = a >> y[5:0];
                    end
                endcase
                return r;
            end
            cls_op_w, cls_op_imm_w: begin
                if (e.funct3 == f3_sll) wr = aw << y[4:0];
                else if (e.funct3 == f3_sr && alt) wr = $signed(aw) >>> y[4:0];
                else if (e.funct3 == f3_sr) wr = aw >> y[4:0];
                else if (e.funct3 == f3_add_sub && reg_form && alt) wr = aw - y[word_w-1:0];
                else wr = aw + y[word_w-1:0];
                return sext_word(wr);
            end
            default: return a + b;
        endcase
    endfunction

    task automatic ref_model(input id_ex_t e, input fwd_t m, input fwd_t w, input logic rdy,
                             output ex_mem_t em, output redirect_t rd);
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic            taken;
        logic            backward;
        a = bypass(e.rs1, e.src_a, 1'b1, m, w);
        b = bypass(e.rs2, e.src_b, e.op_class inside {cls_branch, cls_store, cls_op, cls_op_w},
                   m, w);
        em.valid      = e.valid;
        em.pc         = e.pc;
        em.op_class   = e.op_class;
        em.funct3     = e.funct3;
        em.rd         = e.rd;
        em.alu_result = ref_alu(e, a, b);
        em.store_data = b;
        case (e.funct3)
            beq:     taken = a == b;
            bne:     taken = a != b;
            blt:     taken = $signed(a) < $signed(b);
            bge:     taken = $signed(a) >= $signed(b);
            bltu:    taken = a < b;
            bgeu:    taken = a >= b;
            default: taken = 1'b0;
        endcase
        // static guess is taken for backward offsets
        backward     = e.imm[12];
        rd.pc_update = e.valid && rdy && ((e.op_class == cls_jalr) ||
                       ((e.op_class == cls_branch) && (taken != backward)));
        if (e.op_class == cls_jalr) rd.dnpc = a + e.imm;
        else if ((e.op_class == cls_branch) && !backward) rd.dnpc = e.pc + e.imm;
        else rd.dnpc = e.pc + 64'd4;
    endtask

    task automatic add_row(input string name, input id_ex_t e, input fwd_t m, input fwd_t w,
                           input logic rdy);
        ex_mem_t   em;
        redirect_t rd;
        ref_model(e, m, w, rdy, em, rd);
        row_name.push_back(name);
        row_id.push_back(e);
        row_mem.push_back(m);
        row_wb.push_back(w);
        row_rdy.push_back(rdy);
        row_exp_em.push_back(em);
        row_exp_rd.push_back(rd);
    endtask

    task automatic build_table();
        logic [2:0]           br_f3[6];
        logic [xlen-1:0]      a;
        logic [xlen-1:0]      b;
        logic [xlen-1:0]      r;
        logic [xlen-1:0]      off;
        logic [reg_idx_w-1:0] sh5;
        logic                 alt;
        int                   f;
        int                   c;
        int                   d;
        int                   t;
        br_f3 = '{beq, bne, blt, bge, bltu, bgeu};
        // all register and immediate functions
        for (f = 0; f < 8; f++) begin
            add_row($sformatf("op f3=%0d", f), make_entry(cls_op, 3'(f), 5'd1, 5'd2,
                    rand64(), rand64(), '0), '0, '0, 1'b1);
            add_row($sformatf("op_imm f3=%0d", f), make_entry(cls_op_imm, 3'(f), 5'd1, 5'd2,
                    rand64(), rand64(), rand_imm12()), '0, '0, 1'b1);
        end
        add_row("sub", make_entry(cls_op, f3_add_sub, 5'd1, 5'd2, rand64(), rand64(),
                64'h400), '0, '0, 1'b1);
        add_row("sra", make_entry(cls_op, f3_sr, 5'd1, 5'd2, rand64() | 64'h8000_0000_0000_0000,
                rand64(), 64'h400), '0, '0, 1'b1);
        add_row("srai", make_entry(cls_op_imm, f3_sr, 5'd1, 5'd2, rand64() | {1'b1, 63'd0},
                '0, 64'h427), '0, '0, 1'b1);
        add_row("srli", make_entry(cls_op_imm, f3_sr, 5'd1, 5'd2, rand64(), '0, 64'h02b),
                '0, '0, 1'b1);
        r = rand64();
        add_row("lui", make_entry(cls_lui, 3'd0, 5'd0, 5'd0, '0, '0,
                {{32{r[31]}}, r[31:12], 12'd0}), '0, '0, 1'b1);
        add_row("auipc", make_entry(cls_auipc, 3'd0, 5'd0, 5'd0, '0, '0,
                {{32{r[31]}}, r[31:12], 12'd0}), '0, '0, 1'b1);
        add_row("jal link", make_entry(cls_jal, 3'd0, 5'd0, 5'd0, '0, '0, 64'h100), '0, '0, 1'b1);
        // word ops, random then shifts by 0 and 31
        add_row("addw", make_entry(cls_op_w, f3_add_sub, 5'd1, 5'd2, rand64(), rand64(), '0),
                '0, '0, 1'b1);
        add_row("subw", make_entry(cls_op_w, f3_add_sub, 5'd1, 5'd2, rand64(), rand64(),
                64'h400), '0, '0, 1'b1);
        add_row("addiw", make_entry(cls_op_imm_w, f3_add_sub, 5'd1, 5'd2, rand64(), '0,
                rand_imm12()), '0, '0, 1'b1);
        a = 64'h1234_5678_8765_4321;
        for (f = 0; f < 3; f++) begin
            for (t = 0; t < 3; t++) begin
                sh5 = (t == 0) ? 5'd0 : ((t == 1) ? 5'd31 : 5'(rand64()));
                alt = (f == 2);
                r   = rand64();
                b   = {r[xlen-1:5], sh5};
                add_row($sformatf("shift w kind=%0d sh=%0d", f, sh5), make_entry(cls_op_w,
                        (f == 0) ? f3_sll : f3_sr, 5'd1, 5'd2, a, b, {53'd0, alt, 10'd0}),
                        '0, '0, 1'b1);
                add_row($sformatf("shift iw kind=%0d sh=%0d", f, sh5), make_entry(cls_op_imm_w,
                        (f == 0) ? f3_sll : f3_sr, 5'd1, 5'd2, a, '0,
                        {53'd0, alt, 5'd0, sh5}), '0, '0, 1'b1);
            end
        end
        // forwarding, rs1 is x5 and rs2 is x6
        add_row("fwd mem over wb", make_entry(cls_op, f3_add_sub, 5'd5, 5'd2, rand64(),
                rand64(), '0), make_fwd(1'b1, 5'd5, rand64()), make_fwd(1'b1, 5'd5, rand64()),
                1'b1);
        add_row("fwd wb only", make_entry(cls_op, f3_xor, 5'd5, 5'd6, rand64(), rand64(), '0),
                make_fwd(1'b1, 5'd9, rand64()), make_fwd(1'b1, 5'd5, rand64()), 1'b1);
        add_row("fwd mem idle", make_entry(cls_op, f3_or, 5'd5, 5'd6, rand64(), rand64(), '0),
                make_fwd(1'b0, 5'd5, rand64()), make_fwd(1'b1, 5'd5, rand64()), 1'b1);
        add_row("fwd rs2 mem", make_entry(cls_op_w, f3_add_sub, 5'd1, 5'd6, rand64(), rand64(),
                '0), make_fwd(1'b1, 5'd6, rand64()), make_fwd(1'b1, 5'd6, rand64()), 1'b1);
        add_row("fwd x0", make_entry(cls_op, f3_add_sub, 5'd0, 5'd0, rand64(), rand64(), '0),
                make_fwd(1'b1, 5'd0, rand64()), make_fwd(1'b1, 5'd0, rand64()), 1'b1);
        add_row("fwd op_imm no rs2", make_entry(cls_op_imm, f3_add_sub, 5'd5, 5'd6, rand64(),
                rand64(), rand_imm12()), make_fwd(1'b1, 5'd6, rand64()), '0, 1'b1);
        add_row("fwd store data", make_entry(cls_store, 3'd3, 5'd5, 5'd6, rand64(), rand64(),
                rand_imm12()), '0, make_fwd(1'b1, 5'd6, rand64()), 1'b1);
        // six conditions, forward and backward, taken and not taken
        for (c = 0; c < 6; c++) begin
            for (d = 0; d < 2; d++) begin
                for (t = 0; t < 2; t++) begin
                    off = (d == 1) ? 64'hffff_ffff_ffff_ffc0 : 64'd64;
                    r   = rand64();
                    if (c < 2) begin
                        a = r;
                        b = ((c == 0) == (t == 1)) ? r : ~r;
                    end else if (((c == 2) || (c == 5)) == (t == 1)) begin
                        a = 64'hffff_ffff_ffff_fffb;
                        b = 64'd3;
                    end else begin
                        a = 64'd3;
                        b = 64'hffff_ffff_ffff_fffb;
                    end
                    add_row($sformatf("branch f3=%0d back=%0d taken=%0d", br_f3[c], d, t),
                            make_entry(cls_branch, br_f3[c], 5'd1, 5'd2, a, b, off),
                            '0, '0, 1'b1);
                end
            end
        end
        add_row("branch stalled", make_entry(cls_branch, bne, 5'd1, 5'd2, 64'd7, 64'd7,
                64'hffff_ffff_ffff_ff00), '0, '0, 1'b0);
        add_row("jalr", make_entry(cls_jalr, 3'd0, 5'd1, 5'd0, rand64(), '0, rand_imm12()),
                '0, '0, 1'b1);
        add_row("jalr odd target", make_entry(cls_jalr, 3'd0, 5'd1, 5'd0, 64'h8000_0101, '0,
                64'd4), '0, '0, 1'b1);
        add_row("jalr fwd rs1", make_entry(cls_jalr, 3'd0, 5'd5, 5'd0, rand64(), '0,
                rand_imm12()), make_fwd(1'b1, 5'd5, rand64()), '0, 1'b1);
    endtask

    task automatic check_ex_mem(input string name, input ex_mem_t expected, input ex_mem_t actual);
        if (actual !== expected) begin
            mismatches++;
            $display("Fail %s: ex_mem expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_redirect(input string name, input redirect_t expected,
                                  input redirect_t actual);
        if (actual !== expected) begin
            mismatches++;
            $display("Fail %s: redirect expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            mismatches++;
            $display("Fail %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    // returns just after the edge that takes id_ex
    task automatic wait_accept(input string name);
        int n;
        n = 0;
        @(negedge clk);
        while (!ready_id_ex && n < wait_limit) begin
            n++;
            @(negedge clk);
        end
        if (!ready_id_ex) begin
            timeouts++;
            $display("Timeout: %s never accepted, ready_id_ex stayed low", name);
        end
        @(posedge clk);
    endtask

    task automatic run_table();
        int i;
        for (i = 0; (i < row_name.size()) && (timeouts == 0); i++) begin
            @(posedge clk);
            #drive_dly;
            id_ex        = row_id[i];
            mem_fwd      = '0;
            wb_fwd       = '0;
            ready_ex_mem = 1'b1;
            wait_accept(row_name[i]);
            #drive_dly;
            // row held now, forwarding applies this cycle
            id_ex        = '0;
            mem_fwd      = row_mem[i];
            wb_fwd       = row_wb[i];
            ready_ex_mem = row_rdy[i];
            @(negedge clk);
            check_ex_mem(row_name[i], row_exp_em[i], ex_mem);
            check_redirect(row_name[i], row_exp_rd[i], redirect);
        end
    endtask

    task automatic run_stall_flush();
        id_ex_t    held;
        id_ex_t    next;
        ex_mem_t   em;
        redirect_t rd;
        int        n;
        // backward beq not taken, a mispredict if it could leave
        held = make_entry(cls_branch, beq, 5'd3, 5'd4, 64'd1, 64'd2, 64'hffff_ffff_ffff_ff80);
        next = make_entry(cls_op, f3_add_sub, 5'd3, 5'd4, rand64(), rand64(), '0);
        @(posedge clk);
        #drive_dly;
        id_ex        = held;
        mem_fwd      = '0;
        wb_fwd       = '0;
        ready_ex_mem = 1'b1;
        wait_accept("stall load");
        #drive_dly;
        id_ex        = next;
        ready_ex_mem = 1'b0;
        ref_model(held, '0, '0, 1'b0, em, rd);
        @(negedge clk);
        check_ex_mem("stall held", em, ex_mem);
        check_redirect("stall held", rd, redirect);
        for (n = 0; n < 3; n++) begin
            @(negedge clk);
            check_ex_mem("stall stable", em, ex_mem);
            check_bit("stall ready_id_ex", 1'b0, ready_id_ex);
            check_bit("stall pc_update", 1'b0, redirect.pc_update);
        end
        // flush while mem still stalls
        @(posedge clk);
        #drive_dly;
        branch_flush = 1'b1;
        @(posedge clk);
        #drive_dly;
        branch_flush = 1'b0;
        @(negedge clk);
        check_bit("flush valid", 1'b0, ex_mem.valid);
        check_bit("flush pc_update", 1'b0, redirect.pc_update);
        // waiting entry lands once mem frees up
        @(posedge clk);
        #drive_dly;
        ready_ex_mem = 1'b1;
        wait_accept("release");
        #drive_dly;
        id_ex = '0;
        ref_model(next, '0, '0, 1'b1, em, rd);
        @(negedge clk);
        check_ex_mem("release", em, ex_mem);
        check_redirect("release", rd, redirect);
    endtask

    initial begin
        seed         = 1;
        mismatches   = 0;
        timeouts     = 0;
        arst_n       = 1'b0;
        id_ex        = '0;
        mem_fwd      = '0;
        wb_fwd       = '0;
        ready_ex_mem = 1'b0;
        branch_flush = 1'b0;
        build_table();
        repeat (5) @(posedge clk);
        #drive_dly;
        arst_n = 1'b1;
        @(negedge clk);
        check_bit("reset valid", 1'b0, ex_mem.valid);
        check_bit("reset pc_update", 1'b0, redirect.pc_update);
        run_table();
        if (timeouts == 0) begin
            run_stall_flush();
        end
        $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if ((mismatches == 0) && (timeouts == 0)) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== tb_exu_props.sv ====
module tb_exu_props
    import exu_pkg::*;
(
    input logic      clk,
    input logic      arst_n,
    input logic      ready_id_ex,
    input logic      ready_ex_mem,
    input logic      branch_flush,
    input id_ex_t    entry,
    input ex_mem_t   ex_mem,
    input redirect_t redirect
);

    // decode stalls only when mem stalls
    ready_follows_mem: assert property (@(posedge clk) disable iff (!arst_n)
        ready_id_ex == ready_ex_mem)
        else $error("ready_id_ex differs from ready_ex_mem");

    // redirect only from a valid entry that leaves
    redirect_needs_exit: assert property (@(posedge clk) disable iff (!arst_n)
        redirect.pc_update |-> (entry.valid && ready_ex_mem))
        else $error("pc_update without a valid entry leaving ex");

    // flushed entry gone one cycle later
    flush_clears_entry: assert property (@(posedge clk) disable iff (!arst_n)
        branch_flush |=> !ex_mem.valid)
        else $error("ex_mem still valid after branch_flush");

endmodule

bind exu_top tb_exu_props u_props (
    .clk          (clk),
    .arst_n       (arst_n),
    .ready_id_ex  (ready_id_ex),
    .ready_ex_mem (ready_ex_mem),
    .branch_flush (branch_flush),
    .entry        (entry),
    .ex_mem       (ex_mem),
    .redirect     (redirect)
);

// ==== vlog.f ====
exu_pkg.sv
ex_issue_reg.sv
operand_forward.sv
alu_core.sv
branch_resolve.sv
exu_top.sv
tb_exu_props.sv
tb_exu.sv
